// ==== src/quad_pkg.sv ====
// ********************
// Widths, register map and control bits shared by the whole peripheral
// Register addresses are offsets inside the 8-bit register field
// ********************
package quad_pkg;

    // Bus geometry
    localparam int DBUS_WIDTH        = 8;
    localparam int PERIPH_ADDR_WIDTH = 4;   // Upper address bits
    localparam int REG_ADDR_WIDTH    = 8;   // Lower address bits
    localparam int ADDR_WIDTH        = PERIPH_ADDR_WIDTH + REG_ADDR_WIDTH;

    // Encoder side
    localparam int COUNT_WIDTH = 16;
    localparam int NUM_CHAN    = 2;

    // Register map
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CTRL  = 8'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_Q0_LO = 8'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_Q0_HI = 8'd2;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_Q1_LO = 8'd3;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_Q1_HI = 8'd4;

    // Control register bits
    localparam int CTRL_Q0_EN   = 0;    // Channel 0 snapshot enable
    localparam int CTRL_Q1_EN   = 1;    // Channel 1 snapshot enable
    localparam int CTRL_INTR_EN = 2;    // Interrupt enable

    // Vector types
    typedef logic [DBUS_WIDTH-1:0]  dbus_t;
    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;   // Two's complement count

endpackage

// ==== src/hba_bus_if.sv ====
// ********************
// HBA slave bus bundle, no clock inside
// ********************
interface hba_bus_if;
    import quad_pkg::*;

    logic  rnw;          // 1 = read, 0 = write
    logic  select;       // Transfer in progress
    addr_t abus;
    dbus_t dbus;         // Write data from master
    dbus_t dbus_slave;   // Read data, zero when idle
    logic  xferack;      // One-cycle transfer ack

    // Register bank side
    modport slave (
        input  rnw, select, abus, dbus,
        output dbus_slave, xferack
    );

    // Top-level side
    modport master (
        output rnw, select, abus, dbus,
        input  dbus_slave, xferack
    );

endinterface

// ==== src/quad_decoder.sv ====
// ********************
// Pins must hold each level for at least 2 clocks
// No glitch filter beyond the two-flop synchronizer
// ********************
module quad_decoder (
    input  logic hba_clk,
    input  logic rst_n,
    input  logic enc_a,
    input  logic enc_b,
    output logic step,   // One-cycle pulse per valid transition
    output logic dir     // 1 = up
);

    logic [1:0] sync1_q;   // {a, b}, first stage
    logic [1:0] sync2_q;   // Synchronized state
    logic [1:0] prev_q;    // State one clock earlier
    logic [1:0] delta;
    logic       one_bit;

    assign delta   = sync2_q ^ prev_q;
    assign one_bit = delta[1] ^ delta[0];   // Exactly one pin moved

    always_ff @(posedge hba_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
            step    <= 1'b0;
            dir     <= 1'b0;
        end else begin
            sync1_q <= {enc_a, enc_b};
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            step    <= one_bit;    // Both pins together is dropped
            // A leading B gives new A differing from old B
            if (one_bit) begin
                dir <= sync2_q[1] ^ prev_q[0];
            end
        end
    end

    // Holds as long as the pins respect the minimum level time
    a_step_single: assert property (
        @(posedge hba_clk) disable iff (!rst_n)
        step |=> !step
    ) else $error("step high for more than one cycle");

endmodule

// ==== src/pulse_counter.sv ====
// ********************
// Free-running count, wraps modulo 2^16
// No preset, no overflow flag
// ********************
module pulse_counter (
    input  logic             hba_clk,
    input  logic             rst_n,
    input  logic             step,
    input  logic             dir,     // 1 = up
    output quad_pkg::count_t count,
    output logic             valid    // New count this cycle
);
    import quad_pkg::*;

    count_t next_count;

    // Plain add keeps the modulo wrap
    assign next_count = dir ? count + count_t'(1) : count - count_t'(1);

    always_ff @(posedge hba_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            valid <= 1'b0;
        end else begin
            if (step) begin
                count <= next_count;
            end
            valid <= step;   // Marks the updated count
        end
    end

    // Register bank relies on valid lining up with the new count
    a_valid_marks_change: assert property (
        @(posedge hba_clk) disable iff (!rst_n)
        valid == (count != $past(count))
    ) else $error("valid does not line up with a count change");

endmodule

// ==== src/hba_reg_bank.sv ====
// ********************
// Master must drop select for a cycle between transfers
// Only the control register is writable
// ********************
module hba_reg_bank #(
    parameter logic [quad_pkg::PERIPH_ADDR_WIDTH-1:0] PERIPH_ADDR = '0
) (
    input  logic                          hba_clk,
    input  logic                          rst_n,
    hba_bus_if.slave                      bus,
    input  quad_pkg::count_t              count0,
    input  quad_pkg::count_t              count1,
    input  logic [quad_pkg::NUM_CHAN-1:0] valid,
    output logic                          int_pulse
);
    import quad_pkg::*;

    logic                      periph_hit;
    logic [REG_ADDR_WIDTH-1:0] reg_addr;
    logic                      sel_q;        // Select one clock back
    logic                      xfer_start;
    logic                      ack_q;
    logic [CTRL_INTR_EN:0]     ctrl_q;       // 3 control bits
    count_t                    snap0_q;
    count_t                    snap1_q;
    dbus_t                     rd_mux;
    dbus_t                     rd_q;

    assign periph_hit = bus.abus[ADDR_WIDTH-1 -: PERIPH_ADDR_WIDTH] == PERIPH_ADDR;
    assign reg_addr   = bus.abus[REG_ADDR_WIDTH-1:0];
    assign xfer_start = bus.select && !sel_q && periph_hit;   // First sample only

    assign bus.xferack    = ack_q;
    assign bus.dbus_slave = rd_q;

    // Fires for every new count, either channel
    assign int_pulse = (|valid) && ctrl_q[CTRL_INTR_EN];

    // Read mux
    always_comb begin
        case (reg_addr)
            REG_CTRL:  rd_mux = dbus_t'(ctrl_q);   // Upper bits read zero
            REG_Q0_LO: rd_mux = snap0_q[DBUS_WIDTH-1:0];
            REG_Q0_HI: rd_mux = snap0_q[COUNT_WIDTH-1 -: DBUS_WIDTH];
            REG_Q1_LO: rd_mux = snap1_q[DBUS_WIDTH-1:0];
            REG_Q1_HI: rd_mux = snap1_q[COUNT_WIDTH-1 -: DBUS_WIDTH];
            default:   rd_mux = '0;                 // Unmapped
        endcase
    end

    // Handshake and control register
    always_ff @(posedge hba_clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q  <= 1'b0;
            ack_q  <= 1'b0;
            rd_q   <= '0;
            ctrl_q <= '0;
        end else begin
            sel_q <= bus.select;
            ack_q <= xfer_start;                              // One cycle later
            rd_q  <= (xfer_start && bus.rnw) ? rd_mux : '0;   // Zero outside ack
            if (xfer_start && !bus.rnw && reg_addr == REG_CTRL) begin
                ctrl_q <= bus.dbus[CTRL_INTR_EN:0];
            end
        end
    end

    // Snapshot bytes, frozen while the channel enable is clear
    always_ff @(posedge hba_clk or negedge rst_n) begin
        if (!rst_n) begin
            snap0_q <= '0;
            snap1_q <= '0;
        end else begin
            if (valid[0] && ctrl_q[CTRL_Q0_EN]) begin
                snap0_q <= count0;
            end
            if (valid[1] && ctrl_q[CTRL_Q1_EN]) begin
                snap1_q <= count1;
            end
        end
    end

    // Select held through the ack must not retrigger
    a_ack_single: assert property (
        @(posedge hba_clk) disable iff (!rst_n)
        bus.xferack |=> !bus.xferack
    ) else $error("xferack high two cycles in a row");

    a_rdata_idle_zero: assert property (
        @(posedge hba_clk) disable iff (!rst_n)
        !bus.xferack |-> bus.dbus_slave == '0
    ) else $error("dbus_slave nonzero without xferack");

endmodule

// ==== src/hba_quad.sv ====
// ********************
// Two quadrature encoders on the HBA bus, 4x decoding
// Disable a channel's enable bit to freeze its count before reading
// ********************
module hba_quad #(
    parameter logic [quad_pkg::PERIPH_ADDR_WIDTH-1:0] PERIPH_ADDR = '0
) (
    input  logic                          hba_clk,
    input  logic                          rst_n,
    input  logic                          hba_rnw,            // 1 = read
    input  logic                          hba_select,
    input  quad_pkg::addr_t               hba_abus,
    input  quad_pkg::dbus_t               hba_dbus,
    output quad_pkg::dbus_t               hba_dbus_slave,
    output logic                          hba_xferack_slave,
    output logic                          int_pulse,          // New count interrupt
    input  logic [quad_pkg::NUM_CHAN-1:0] quad_enc_a,
    input  logic [quad_pkg::NUM_CHAN-1:0] quad_enc_b
);
    import quad_pkg::*;

    hba_bus_if bus ();

    logic [NUM_CHAN-1:0] step;
    logic [NUM_CHAN-1:0] dir;
    logic [NUM_CHAN-1:0] cnt_valid;
    count_t              cnt [NUM_CHAN];

    // Master side of the bundle
    assign bus.rnw    = hba_rnw;
    assign bus.select = hba_select;
    assign bus.abus   = hba_abus;
    assign bus.dbus   = hba_dbus;

    assign hba_dbus_slave    = bus.dbus_slave;
    assign hba_xferack_slave = bus.xferack;

    // One decoder and counter per encoder
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        quad_decoder i_quad_decoder (
            .hba_clk (hba_clk),
            .rst_n   (rst_n),
            .enc_a   (quad_enc_a[i]),
            .enc_b   (quad_enc_b[i]),
            .step    (step[i]),
            .dir     (dir[i])
        );

        pulse_counter i_pulse_counter (
            .hba_clk (hba_clk),
            .rst_n   (rst_n),
            .step    (step[i]),
            .dir     (dir[i]),
            .count   (cnt[i]),
            .valid   (cnt_valid[i])
        );
    end

    hba_reg_bank #(
        .PERIPH_ADDR (PERIPH_ADDR)
    ) i_hba_reg_bank (
        .hba_clk   (hba_clk),
        .rst_n     (rst_n),
        .bus       (bus.slave),
        .count0    (cnt[0]),
        .count1    (cnt[1]),
        .valid     (cnt_valid),
        .int_pulse (int_pulse)
    );

endmodule

// ==== sim/tb_hba_quad.sv ====
// ********************
// Directed testbench, DUT placed at peripheral field 3
// Encoder pins hold each level 10 clocks, well past the 5-clock latency
// ********************
module tb_hba_quad;
    timeunit 1ns;
    timeprecision 100ps;
    import quad_pkg::*;

    localparam logic [PERIPH_ADDR_WIDTH-1:0] PERIPH = 4'd3;
    localparam int ACK_TIMEOUT = 20;   // Clocks allowed for an ack

    logic                hba_clk;
    logic                rst_n;
    logic                hba_rnw;
    logic                hba_select;
    addr_t               hba_abus;
    dbus_t               hba_dbus;
    dbus_t               hba_dbus_slave;
    logic                hba_xferack_slave;
    logic                int_pulse;
    logic [NUM_CHAN-1:0] quad_enc_a;
    logic [NUM_CHAN-1:0] quad_enc_b;

    count_t     model [NUM_CHAN];   // Scoreboard count per channel
    logic [1:0] phase [NUM_CHAN];   // Gray position 0..3 of each encoder
    int         int_total = 0;      // Interrupt cycles seen so far

    hba_quad #(
        .PERIPH_ADDR (PERIPH)
    ) i_hba_quad (
        .hba_clk           (hba_clk),
        .rst_n             (rst_n),
        .hba_rnw           (hba_rnw),
        .hba_select        (hba_select),
        .hba_abus          (hba_abus),
        .hba_dbus          (hba_dbus),
        .hba_dbus_slave    (hba_dbus_slave),
        .hba_xferack_slave (hba_xferack_slave),
        .int_pulse         (int_pulse),
        .quad_enc_a        (quad_enc_a),
        .quad_enc_b        (quad_enc_b)
    );

    initial begin
        hba_clk = 1'b0;
        forever #10 hba_clk = ~hba_clk;   // 20 ns period
    end

    // Pre-edge sample, one count per pulse cycle
    always @(posedge hba_clk) begin
        if (int_pulse) int_total <= int_total + 1;
    end

    task automatic check(input count_t actual, input count_t expected, input string msg);
        if (actual !== expected) begin
            $display("Error at time %0d ns: %s, got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Ack expected on the second edge after select goes up
    task automatic wait_ack(input string what, output dbus_t rdata);
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; n < ACK_TIMEOUT && !seen; n++) begin
            @(posedge hba_clk);
            if (hba_xferack_slave) begin
                seen  = 1'b1;
                rdata = hba_dbus_slave;   // Valid only in the ack cycle
                check(count_t'(n), count_t'(1), {what, " ack latency"});
            end
        end
        if (!seen) begin
            $display("Timeout: the %s got no transfer acknowledge", what);
            $display("Simulation finished: FAIL");
            $fatal(1, "Bus timeout");
        end
    endtask

    task automatic bus_write(input logic [REG_ADDR_WIDTH-1:0] reg_sel, input dbus_t data);
        dbus_t unused;
        @(posedge hba_clk);   // One idle edge keeps select low between transfers
        hba_abus   <= {PERIPH, reg_sel};
        hba_dbus   <= data;
        hba_rnw    <= 1'b0;
        hba_select <= 1'b1;
        wait_ack("write", unused);
        hba_select <= 1'b0;
    endtask

    task automatic bus_read(input logic [REG_ADDR_WIDTH-1:0] reg_sel, output dbus_t data);
        @(posedge hba_clk);
        hba_abus   <= {PERIPH, reg_sel};
        hba_rnw    <= 1'b1;
        hba_select <= 1'b1;
        wait_ack("read", data);
        hba_select <= 1'b0;
    endtask

    // Both snapshot bytes against the scoreboard
    task automatic check_chan(input logic chan, input string msg);
        dbus_t lo;
        dbus_t hi;
        bus_read(chan ? REG_Q1_LO : REG_Q0_LO, lo);
        bus_read(chan ? REG_Q1_HI : REG_Q0_HI, hi);
        check({hi, lo}, model[chan], msg);
    endtask

    // Up walks {a,b} 00,10,11,01 so A leads B
    task automatic enc_step(input logic chan, input bit up);
        logic [1:0] nxt_phase;
        nxt_phase    = up ? phase[chan] + 2'd1 : phase[chan] - 2'd1;
        phase[chan]  = nxt_phase;
        model[chan]  = up ? model[chan] + count_t'(1) : model[chan] - count_t'(1);
        @(posedge hba_clk);
        quad_enc_a[chan] <= (nxt_phase == 2'd1) || (nxt_phase == 2'd2);
        quad_enc_b[chan] <= (nxt_phase == 2'd2) || (nxt_phase == 2'd3);
        repeat (10) @(posedge hba_clk);
    endtask

    task automatic test_reset_values;
        dbus_t rd;
        check(count_t'(hba_xferack_slave), 16'h0, "xferack after reset");
        check(count_t'(hba_dbus_slave), 16'h0, "dbus_slave after reset");
        check(count_t'(int_pulse), 16'h0, "int_pulse after reset");
        for (int r = 0; r <= 4; r++) begin
            bus_read(REG_ADDR_WIDTH'(r), rd);
            check(count_t'(rd), 16'h0, "register after reset");
        end
        bus_write(REG_CTRL, 8'h07);
        bus_read(REG_CTRL, rd);
        check(count_t'(rd), 16'h7, "control read-back");
        bus_read(8'd5, rd);   // Unmapped
        check(count_t'(rd), 16'h0, "unmapped address");
    endtask

    task automatic test_single_channel;
        int n_up;
        int n_down;
        bus_write(REG_CTRL, 8'h01);   // Channel 0 only
        n_up   = $urandom_range(40, 1);
        n_down = $urandom_range(40, 1);
        repeat (n_up) enc_step(1'b0, 1'b1);
        repeat (n_down) enc_step(1'b0, 1'b0);   // May go negative
        check_chan(1'b0, "channel 0 up/down");
        check_chan(1'b1, "channel 1 untouched");
    endtask

    // Channel 0 always steps against channel 1
    task automatic test_both_channels;
        int n_up;
        int n_down;
        bus_write(REG_CTRL, 8'h03);
        n_up   = $urandom_range(40, 1);
        n_down = $urandom_range(40, 1);
        repeat (n_up) begin
            enc_step(1'b1, 1'b1);
            enc_step(1'b0, 1'b0);
        end
        repeat (n_down) begin
            enc_step(1'b1, 1'b0);
            enc_step(1'b0, 1'b1);
        end
        check_chan(1'b0, "channel 0 opposite");
        check_chan(1'b1, "channel 1 independent");
    endtask

    task automatic test_freeze;
        count_t frozen;
        dbus_t  lo;
        dbus_t  hi;
        int     n;
        frozen = model[0];
        bus_write(REG_CTRL, 8'h02);   // Channel 0 snapshot held
        n = $urandom_range(10, 1);
        repeat (n) enc_step(1'b0, 1'b1);
        bus_read(REG_Q0_LO, lo);
        bus_read(REG_Q0_HI, hi);
        check({hi, lo}, frozen, "channel 0 frozen");
        bus_write(REG_CTRL, 8'h03);
        enc_step(1'b0, 1'b1);         // Next step reloads the full count
        check_chan(1'b0, "channel 0 after re-enable");
    endtask

    task automatic test_interrupt;
        int start;
        int n;
        bus_write(REG_CTRL, 8'h07);
        start = int_total;
        n = $urandom_range(20, 1);
        repeat (n) enc_step(1'b1, 1'b0);
        check(count_t'(int_total - start), count_t'(n), "interrupt pulses enabled");
        bus_write(REG_CTRL, 8'h03);
        start = int_total;
        repeat (5) enc_step(1'b1, 1'b1);
        check(count_t'(int_total - start), 16'h0, "interrupt pulses disabled");
        check_chan(1'b1, "channel 1 after interrupt test");
    endtask

    // Write of zero to peripheral 2 must be ignored here
    task automatic test_other_periph;
        bit    acked;
        dbus_t rd;
        acked = 1'b0;
        @(posedge hba_clk);
        hba_abus   <= {4'd2, REG_CTRL};
        hba_dbus   <= 8'h00;
        hba_rnw    <= 1'b0;
        hba_select <= 1'b1;
        for (int n = 0; n < 20; n++) begin
            @(posedge hba_clk);
            if (hba_xferack_slave) acked = 1'b1;
        end
        hba_select <= 1'b0;
        if (acked) begin
            $display("A transfer to peripheral 2 was acknowledged by this peripheral");
            $display("Simulation finished: FAIL");
            $fatal(1, "Foreign ack");
        end
        bus_read(REG_CTRL, rd);
        check(count_t'(rd), 16'h3, "control after foreign write");
        check_chan(1'b0, "channel 0 after foreign write");
        check_chan(1'b1, "channel 1 after foreign write");
    endtask

    initial begin
        void'($urandom(7));
        rst_n      = 1'b0;
        hba_rnw    = 1'b1;
        hba_select = 1'b0;
        hba_abus   = '0;
        hba_dbus   = '0;
        quad_enc_a = '0;
        quad_enc_b = '0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            model[c] = '0;
            phase[c] = 2'd0;
        end
        repeat (2) @(posedge hba_clk);
        rst_n <= 1'b1;
        @(posedge hba_clk);
        test_reset_values;
        test_single_channel;
        test_both_channels;
        test_freeze;
        test_interrupt;
        test_other_periph;
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
src/quad_pkg.sv
src/hba_bus_if.sv
src/quad_decoder.sv
src/pulse_counter.sv
src/hba_reg_bank.sv
src/hba_quad.sv
sim/tb_hba_quad.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hba_quad testbench with Verilator
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
    --top-module tb_hba_quad \
    -f flist.f \
    -o sim_hba_quad
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_hba_quad
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
